//--- Makefile
# Verilator build for the video controller testbench

VERILATOR    ?= verilator
TOP          := video_core_tb
FILELIST     := video_core.f
BUILD_DIR    := obj_dir
COMMON_FLAGS := --timing --assert --top-module $(TOP)
LINT_FLAGS   := --lint-only $(COMMON_FLAGS)
SIM_FLAGS    := --binary -j 0 $(COMMON_FLAGS) --Mdir $(BUILD_DIR)
# let bound $error checks run on so the testbench can report them
RUN_ARGS     := +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

//--- design/bus_regs.sv
`default_nettype none
`timescale 1ns/1ps

module bus_regs #(
    parameter int VRAM_AW = 12
) (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      cs_n_i,
    input  wire                      rd_nwr_i,
    input  wire video_pkg::reg_num_t reg_num_i,
    input  wire                      bytesel_i,
    input  wire video_pkg::byte_t    data_i,
    output video_pkg::byte_t         data_o,
    vram_port_if.requester           mem,
    output logic                     pal_we_o,
    output video_pkg::pix_idx_t      pal_idx_o,
    output video_pkg::color_t        pal_color_o,
    output logic                     video_enable_o
);
    import video_pkg::*;

    localparam word_t ADDR_MASK = word_t'((32'd1 << VRAM_AW) - 32'd1);

    bus_state_e state_q;
    byte_t      hold_hi_q;              // even byte waiting for its odd partner
    logic       wr_even;
    logic       wr_commit;              // odd byte write, word complete
    logic       rd_strobe;
    word_t      wr_word;
    word_t      rd_word;
    word_t      addr_q;                 // vram address register
    word_t      addr_inc;
    pix_idx_t   pal_idx_q;
    word_t      ctrl_q;
    word_t      prefetch_q;             // last word read from vram
    logic       req_wr_q;
    word_t      req_addr_q;
    word_t      req_wdata_q;

    assign wr_even   = cs_n_i == CS_ACTIVE && rd_nwr_i != RNW_READ && !bytesel_i;
    assign wr_commit = cs_n_i == CS_ACTIVE && rd_nwr_i != RNW_READ && bytesel_i;
    assign rd_strobe = cs_n_i == CS_ACTIVE && rd_nwr_i == RNW_READ;
    assign wr_word   = {hold_hi_q, data_i};
    assign addr_inc  = (addr_q + 16'd1) & ADDR_MASK;   // stays inside vram

    // register read mux
    always_comb begin
        case (reg_num_i)
            REG_ADDR:     rd_word = addr_q;
            REG_DATA:     rd_word = prefetch_q;        // prefetched, no wait
            REG_PAL_ADDR: rd_word = word_t'(pal_idx_q);
            REG_CTRL:     rd_word = ctrl_q;
            default:      rd_word = '0;                // palette is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_even) begin
            hold_hi_q <= data_i;                       // high byte first
        end
    end

    // decode: register updates and read data
    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr_q    <= '0;
            pal_idx_q <= '0;
            ctrl_q    <= '0;
            data_o    <= '0;
        end else begin
            if (rd_strobe) begin
                data_o <= bytesel_i ? rd_word[7:0] : rd_word[15:8];  // held till next read
            end
            if (wr_commit) begin
                case (reg_num_i)
                    REG_ADDR:     addr_q    <= wr_word;
                    REG_DATA:     addr_q    <= addr_inc;     // post increment
                    REG_PAL_ADDR: pal_idx_q <= wr_word[3:0];
                    REG_PAL_DATA: pal_idx_q <= pal_idx_q + 1'b1;  // wraps at 16
                    REG_CTRL:     ctrl_q    <= wr_word;
                    default:      ;
                endcase
            end
        end
    end

    // vram access: write then prefetch, or prefetch alone
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q  <= IDLE;
            req_wr_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (wr_commit && (reg_num_i == REG_ADDR || reg_num_i == REG_DATA)) begin
                        req_wr_q <= reg_num_i == REG_DATA;
                        state_q  <= WAIT_GRANT;
                    end
                end
                WAIT_GRANT: begin
                    if (mem.gnt) begin
                        if (req_wr_q) begin
                            req_wr_q <= 1'b0;          // write done, now prefetch
                        end else begin
                            state_q <= WAIT_DATA;
                        end
                    end
                end
                WAIT_DATA: state_q <= IDLE;            // rdata valid this cycle
                default:   state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && wr_commit) begin
            req_addr_q  <= reg_num_i == REG_ADDR ? wr_word : addr_q;
            req_wdata_q <= wr_word;
        end else if (state_q == WAIT_GRANT && mem.gnt && req_wr_q) begin
            req_addr_q <= addr_q;              // already incremented
        end
        if (state_q == WAIT_DATA) begin
            prefetch_q <= mem.rdata;
        end
    end

    assign mem.req   = state_q == WAIT_GRANT;
    assign mem.wr    = req_wr_q;
    assign mem.addr  = req_addr_q;
    assign mem.wdata = req_wdata_q;

    assign pal_we_o       = wr_commit && reg_num_i == REG_PAL_DATA;
    assign pal_idx_o      = pal_idx_q;
    assign pal_color_o    = wr_word[11:0];     // upper nibble dropped
    assign video_enable_o = ctrl_q[0];

endmodule

`default_nettype wire

//--- design/palette_out.sv
`default_nettype none
`timescale 1ns/1ps

module palette_out (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      enable_i,
    input  wire video_pkg::pix_idx_t pix_idx_i,
    input  wire                      hsync_i,
    input  wire                      vsync_i,
    input  wire                      de_i,
    input  wire                      pal_we_i,
    input  wire video_pkg::pix_idx_t pal_idx_i,
    input  wire video_pkg::color_t   pal_color_i,
    output logic [3:0]               red_o,
    output logic [3:0]               green_o,
    output logic [3:0]               blue_o,
    output logic                     hsync_o,
    output logic                     vsync_o,
    output logic                     de_o
);
    import video_pkg::*;

    color_t pal_r [16];                     // sixteen color registers
    color_t lookup;

    assign lookup = pal_r[pix_idx_i];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pal_r <= '{default: '0};        // black palette
        end else if (pal_we_i) begin
            pal_r[pal_idx_i] <= pal_color_i;
        end
    end

    // last pipeline stage, sync passes straight through
    always_ff @(posedge clk) begin
        if (reset_i) begin
            {red_o, green_o, blue_o} <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
        end else begin
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
            de_o    <= de_i;
            {red_o, green_o, blue_o} <= (enable_i && de_i) ? lookup : '0;  // blank
        end
    end

endmodule

`default_nettype wire

//--- design/video_core.sv
`default_nettype none
`timescale 1ns/1ps

module video_core #(
    parameter int VRAM_AW   = 12,
    parameter int H_VISIBLE = 160,
    parameter int H_TOTAL   = 200,
    parameter int V_VISIBLE = 100,
    parameter int V_TOTAL   = 110
) (
    input  wire        clk,
    input  wire        reset_i,
    input  wire        bus_cs_n_i,          // active low strobe
    input  wire        bus_rd_nwr_i,
    input  wire  [3:0] bus_reg_num_i,
    input  wire        bus_bytesel_i,       // 0 high byte, 1 low byte
    input  wire  [7:0] bus_data_i,
    output logic [7:0] bus_data_o,
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       de_o
);
    import video_pkg::*;

    vram_port_if scan_port ();
    vram_port_if host_port ();

    logic     pal_we;
    pix_idx_t pal_idx;
    color_t   pal_color;
    logic     video_enable;
    pix_idx_t scan_pix;
    logic     scan_hsync;
    logic     scan_vsync;
    logic     scan_de;

    bus_regs #(
        .VRAM_AW(VRAM_AW)
    ) bus_regs_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .cs_n_i        (bus_cs_n_i),
        .rd_nwr_i      (bus_rd_nwr_i),
        .reg_num_i     (reg_num_t'(bus_reg_num_i)),
        .bytesel_i     (bus_bytesel_i),
        .data_i        (bus_data_i),
        .data_o        (bus_data_o),
        .mem           (host_port),
        .pal_we_o      (pal_we),
        .pal_idx_o     (pal_idx),
        .pal_color_o   (pal_color),
        .video_enable_o(video_enable)
    );

    vram_arbiter #(
        .VRAM_AW(VRAM_AW)
    ) vram_arbiter_i (
        .clk    (clk),
        .reset_i(reset_i),
        .scan   (scan_port),
        .host   (host_port)
    );

    video_scan #(
        .H_VISIBLE(H_VISIBLE),
        .H_TOTAL  (H_TOTAL),
        .V_VISIBLE(V_VISIBLE),
        .V_TOTAL  (V_TOTAL)
    ) video_scan_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .mem      (scan_port),
        .pix_idx_o(scan_pix),
        .hsync_o  (scan_hsync),
        .vsync_o  (scan_vsync),
        .de_o     (scan_de)
    );

    palette_out palette_out_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .enable_i   (video_enable),
        .pix_idx_i  (scan_pix),
        .hsync_i    (scan_hsync),
        .vsync_i    (scan_vsync),
        .de_i       (scan_de),
        .pal_we_i   (pal_we),
        .pal_idx_i  (pal_idx),
        .pal_color_i(pal_color),
        .red_o      (red_o),
        .green_o    (green_o),
        .blue_o     (blue_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .de_o       (de_o)
    );

endmodule

`default_nettype wire

//--- design/video_pkg.sv
`default_nettype none

package video_pkg;

    typedef logic [15:0] word_t;        // vram word and host register word
    typedef logic [7:0]  byte_t;        // host bus datum
    typedef logic [3:0]  pix_idx_t;     // palette index
    typedef logic [11:0] color_t;       // rgb 4:4:4, red in [11:8]

    // host register numbers
    typedef enum logic [3:0] {
        REG_ADDR     = 4'd0,            // vram word address
        REG_DATA     = 4'd1,            // vram data, auto-increment
        REG_PAL_ADDR = 4'd2,            // palette index
        REG_PAL_DATA = 4'd3,            // palette color, auto-increment
        REG_CTRL     = 4'd4             // bit 0 video enable
    } reg_num_t;

    // host side vram access tracking
    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        WAIT_DATA
    } bus_state_e;

    localparam logic CS_ACTIVE = 1'b0;  // chip select is active low
    localparam logic RNW_READ  = 1'b1;  // rd_nwr high means read

endpackage

`default_nettype wire

//--- design/video_scan.sv
`default_nettype none
`timescale 1ns/1ps

module video_scan #(
    parameter int H_VISIBLE = 160,
    parameter int H_TOTAL   = 200,
    parameter int V_VISIBLE = 100,
    parameter int V_TOTAL   = 110
) (
    input  wire                 clk,
    input  wire                 reset_i,
    vram_port_if.requester      mem,
    output video_pkg::pix_idx_t pix_idx_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                de_o
);
    import video_pkg::*;

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          h_last;
    logic          v_last;
    logic          last_grp;                // last four columns of the line
    logic [HW-1:0] tgt_h;                   // column four ahead
    logic [VW-1:0] tgt_v;                   // line of that column
    logic          fetch;
    logic          fetch_q;
    word_t         addr_q;                  // linear word address in frame
    word_t         next_word_q;
    word_t         shift_q;
    pix_idx_t      pix_q;
    logic [1:0]    hs_q;                    // two stage delay to match pixels
    logic [1:0]    vs_q;
    logic [1:0]    de_q;

    assign h_last   = h_cnt == HW'(H_TOTAL - 1);
    assign v_last   = v_cnt == VW'(V_TOTAL - 1);
    assign last_grp = h_cnt >= HW'(H_TOTAL - 4);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // one group ahead, wrapping into next line and frame
    assign tgt_h = last_grp ? h_cnt - HW'(H_TOTAL - 4) : h_cnt + HW'(4);
    assign tgt_v = !last_grp ? v_cnt : (v_last ? '0 : v_cnt + 1'b1);
    assign fetch = h_cnt[1:0] == 2'd0 && tgt_h < HW'(H_VISIBLE) && tgt_v < VW'(V_VISIBLE);

    assign mem.req   = fetch;               // granted same cycle, top priority
    assign mem.wr    = 1'b0;                // read only
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr_q  <= '0;
            fetch_q <= 1'b0;
        end else begin
            fetch_q <= mem.gnt;
            if (mem.gnt) begin
                addr_q <= addr_q + 1'b1;
            end else if (v_cnt == VW'(V_VISIBLE)) begin
                addr_q <= '0;               // restart in vertical blank
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_q) begin
            next_word_q <= mem.rdata;
        end
        if (h_cnt[1:0] == 2'd0) begin
            shift_q <= next_word_q;         // msn first
        end else begin
            shift_q <= {shift_q[11:0], 4'h0};
        end
        pix_q <= shift_q[15:12];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_q <= '0;
            vs_q <= '0;
            de_q <= '0;
        end else begin
            hs_q <= {hs_q[0], last_grp};
            vs_q <= {vs_q[0], v_cnt >= VW'(V_TOTAL - 2)};
            de_q <= {de_q[0], h_cnt < HW'(H_VISIBLE) && v_cnt < VW'(V_VISIBLE)};
        end
    end

    assign pix_idx_o = pix_q;
    assign hsync_o   = hs_q[1];
    assign vsync_o   = vs_q[1];
    assign de_o      = de_q[1];

endmodule

`default_nettype wire

//--- design/vram_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module vram_arbiter #(
    parameter int VRAM_AW = 12
) (
    input  wire         clk,
    input  wire         reset_i,
    vram_port_if.memory scan,
    vram_port_if.memory host
);
    import video_pkg::*;

    word_t              mem_r [2**VRAM_AW];     // single port word array
    logic               scan_sel;
    logic               host_sel;
    logic [VRAM_AW-1:0] addr;
    logic               wr_en;
    word_t              wdata;
    word_t              ram_q;
    logic               scan_rd_q;              // read data belongs to scan
    logic               host_rd_q;

    // scan engine always wins, host takes the leftover cycles
    assign scan_sel = scan.req;
    assign host_sel = host.req && !scan.req;

    assign addr  = scan_sel ? scan.addr[VRAM_AW-1:0] : host.addr[VRAM_AW-1:0];
    assign wr_en = scan_sel ? scan.wr : (host_sel && host.wr);
    assign wdata = scan_sel ? scan.wdata : host.wdata;

    assign scan.gnt = scan_sel;                 // served this cycle
    assign host.gnt = host_sel;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_r[addr] <= wdata;
        end
        ram_q <= mem_r[addr];                   // old data on write
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scan_rd_q <= 1'b0;
            host_rd_q <= 1'b0;
        end else begin
            scan_rd_q <= scan_sel && !scan.wr;
            host_rd_q <= host_sel && !host.wr;
        end
    end

    // read data only shows on the owner's port
    assign scan.rdata = scan_rd_q ? ram_q : '0;
    assign host.rdata = host_rd_q ? ram_q : '0;

endmodule

`default_nettype wire

//--- design/vram_port_if.sv
`default_nettype none
`timescale 1ns/1ps

// one requester's path into vram
interface vram_port_if;
    import video_pkg::*;

    logic  req;                         // level, held until gnt
    logic  wr;                          // 1 = write, 0 = read
    word_t addr;                        // wraps inside vram
    word_t wdata;
    logic  gnt;                         // one cycle, access done this cycle
    word_t rdata;                       // valid the cycle after gnt

    modport requester (
        output req, wr, addr, wdata,
        input  gnt, rdata
    );

    modport memory (
        input  req, wr, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

//--- tb/video_core_properties.sv
`default_nettype none
`timescale 1ns/1ps

module video_core_properties #(
    parameter int LINE_CYCLES  = 24,        // columns per line incl. blank
    parameter int DE_PER_LINE  = 16,
    parameter int HSYNC_CYCLES = 4,
    parameter int VSYNC_CYCLES = 48,        // two whole lines
    parameter int DE_LINES     = 8
) (
    input wire       clk,
    input wire       reset_i,
    input wire [3:0] red_i,
    input wire [3:0] green_i,
    input wire [3:0] blue_i,
    input wire       hsync_i,
    input wire       vsync_i,
    input wire       de_i
);

    int unsigned fail_count = 0;            // polled by the testbench
    logic        hs_q;
    logic        vs_q;
    logic        de_q;
    int unsigned hs_run;                    // length of current high run
    int unsigned vs_run;
    int unsigned de_run;
    int unsigned hs_period;                 // cycles since last hsync rise, 0 = none yet
    int unsigned de_lines;                  // de rises since last vsync rise

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_q      <= 1'b0;
            vs_q      <= 1'b0;
            de_q      <= 1'b0;
            hs_run    <= 0;
            vs_run    <= 0;
            de_run    <= 0;
            hs_period <= 0;
            de_lines  <= 0;
        end else begin
            hs_q   <= hsync_i;
            vs_q   <= vsync_i;
            de_q   <= de_i;
            hs_run <= hsync_i ? hs_run + 1 : 0;
            vs_run <= vsync_i ? vs_run + 1 : 0;
            de_run <= de_i ? de_run + 1 : 0;
            if (hsync_i && !hs_q) begin
                hs_period <= 1;
            end else if (hs_period != 0) begin
                hs_period <= hs_period + 1;
            end
            // vsync never rises on a visible line
            if (vsync_i && !vs_q) begin
                de_lines <= 0;
            end else if (de_i && !de_q) begin
                de_lines <= de_lines + 1;
            end
        end
    end

    hsync_width: assert property (@(posedge clk) disable iff (reset_i)
        (!hsync_i && hs_q) |-> hs_run == HSYNC_CYCLES)
        else begin
            $error("hsync_o pulse width is %0d, not %0d", hs_run, HSYNC_CYCLES);
            fail_count++;
        end

    hsync_period: assert property (@(posedge clk) disable iff (reset_i)
        (hsync_i && !hs_q && hs_period != 0) |-> hs_period == LINE_CYCLES)
        else begin
            $error("hsync_o period is %0d, not %0d", hs_period, LINE_CYCLES);
            fail_count++;
        end

    de_width: assert property (@(posedge clk) disable iff (reset_i)
        (!de_i && de_q) |-> de_run == DE_PER_LINE)
        else begin
            $error("de_o run is %0d cycles, not %0d", de_run, DE_PER_LINE);
            fail_count++;
        end

    vsync_width: assert property (@(posedge clk) disable iff (reset_i)
        (!vsync_i && vs_q) |-> vs_run == VSYNC_CYCLES)
        else begin
            $error("vsync_o high for %0d cycles, not %0d", vs_run, VSYNC_CYCLES);
            fail_count++;
        end

    de_lines_per_frame: assert property (@(posedge clk) disable iff (reset_i)
        (vsync_i && !vs_q) |-> de_lines == DE_LINES)
        else begin
            $error("frame had %0d lines with de_o, not %0d", de_lines, DE_LINES);
            fail_count++;
        end

    // blanking outside the visible area
    rgb_blank: assert property (@(posedge clk) disable iff (reset_i)
        !de_i |-> {red_i, green_i, blue_i} == 12'h000)
        else begin
            $error("rgb not zero while de_o is low");
            fail_count++;
        end

endmodule

bind video_core video_core_properties props_i (
    .clk    (clk),
    .reset_i(reset_i),
    .red_i  (red_o),
    .green_i(green_o),
    .blue_i (blue_o),
    .hsync_i(hsync_o),
    .vsync_i(vsync_o),
    .de_i   (de_o)
);

`default_nettype wire

//--- tb/video_core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module video_core_tb;
    import video_pkg::*;

    localparam int VRAM_AW        = 8;
    localparam int H_VISIBLE      = 16;
    localparam int H_TOTAL        = 24;
    localparam int V_VISIBLE      = 8;
    localparam int V_TOTAL        = 12;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;          // 288
    localparam int FRAME_PIXELS   = H_VISIBLE * V_VISIBLE;
    localparam int NUM_WORDS      = FRAME_PIXELS / 4;           // four pixels per word
    localparam int ACCESS_GAP     = 6;                          // cycles between bus strobes
    localparam int SETUP_ACCESSES = 140;                        // upper bound on bus strobes
    localparam int WATCHDOG_CYCLES = SETUP_ACCESSES * ACCESS_GAP + 5 * FRAME_CYCLES;

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n;
    logic       bus_rd_nwr;
    logic [3:0] bus_reg_num;
    logic       bus_bytesel;
    logic [7:0] bus_data_in;
    logic [7:0] bus_data_out;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       hsync;
    logic       vsync;
    logic       de;

    word_t  vram_model [NUM_WORDS];     // expected vram contents
    color_t pal_model [16];             // expected palette
    integer seed;

    video_core #(
        .VRAM_AW  (VRAM_AW),
        .H_VISIBLE(H_VISIBLE),
        .H_TOTAL  (H_TOTAL),
        .V_VISIBLE(V_VISIBLE),
        .V_TOTAL  (V_TOTAL)
    ) dut_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_cs_n_i   (bus_cs_n),
        .bus_rd_nwr_i (bus_rd_nwr),
        .bus_reg_num_i(bus_reg_num),
        .bus_bytesel_i(bus_bytesel),
        .bus_data_i   (bus_data_in),
        .bus_data_o   (bus_data_out),
        .red_o        (red),
        .green_o      (green),
        .blue_o       (blue),
        .hsync_o      (hsync),
        .vsync_o      (vsync),
        .de_o         (de)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;         // 100 ns period
    end

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic expect_equal(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        assert (got === exp)
        else begin
            $display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // one strobe cycle, then idle up to the access gap
    task automatic write_byte(input reg_num_t num, input logic sel, input byte_t value);
        @(posedge clk);
        bus_cs_n    <= 1'b0;
        bus_rd_nwr  <= 1'b0;
        bus_reg_num <= num;
        bus_bytesel <= sel;
        bus_data_in <= value;
        @(posedge clk);
        bus_cs_n    <= 1'b1;
        repeat (ACCESS_GAP - 2) @(posedge clk);
    endtask

    task automatic read_byte(input reg_num_t num, input logic sel, output byte_t value);
        @(posedge clk);
        bus_cs_n    <= 1'b0;
        bus_rd_nwr  <= 1'b1;
        bus_reg_num <= num;
        bus_bytesel <= sel;
        @(posedge clk);
        bus_cs_n    <= 1'b1;
        @(negedge clk);
        value = bus_data_out;           // loaded on the edge that ended the strobe
        repeat (ACCESS_GAP - 2) @(posedge clk);
    endtask

    task automatic write_word(input reg_num_t num, input word_t value);
        write_byte(num, 1'b0, value[15:8]);   // high byte held
        write_byte(num, 1'b1, value[7:0]);    // low byte commits
    endtask

    task automatic check_word(input reg_num_t num, input word_t exp);
        byte_t b;
        read_byte(num, 1'b0, b);
        expect_equal($sformatf("bus_data_o (%s high)", num.name()), b, exp[15:8]);
        read_byte(num, 1'b1, b);
        expect_equal($sformatf("bus_data_o (%s low)", num.name()), b, exp[7:0]);
    endtask

    // returns on the first cycle after vsync_o falls
    task automatic wait_frame_start();
        do @(negedge clk); while (!vsync);
        do @(negedge clk); while (vsync);
    endtask

    task automatic check_frame_pixels();
        int       n;
        word_t    w;
        pix_idx_t idx;
        n = 0;
        while (n < FRAME_PIXELS) begin
            if (de) begin
                w   = vram_model[n / 4];
                idx = pix_idx_t'(w >> (12 - 4 * (n % 4)));   // msn first
                expect_equal("{red_o, green_o, blue_o}", 16'({red, green, blue}),
                             16'(pal_model[idx]));
                n++;
            end
            @(negedge clk);
        end
    endtask

    task automatic check_blank_frame();
        int de_cycles;
        de_cycles = 0;
        repeat (FRAME_CYCLES) begin
            if (de) begin
                de_cycles++;
            end
            expect_equal("{red_o, green_o, blue_o}", 16'({red, green, blue}), 16'h0);
            @(negedge clk);
        end
        expect_equal("de_o cycles per frame", 16'(de_cycles), 16'(FRAME_PIXELS));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_with_failure();
    end

    // bound checks count their failures
    initial begin
        wait (dut_i.props_i.fail_count != 0);
        $display("a bound assertion on the video outputs failed");
        stop_with_failure();
    end

    initial begin
        word_t value;
        seed        = 66;
        reset_i     = 1'b1;
        bus_cs_n    = 1'b1;
        bus_rd_nwr  = 1'b1;
        bus_reg_num = 4'h0;
        bus_bytesel = 1'b0;
        bus_data_in = 8'h00;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);

        // reset values
        expect_equal("hsync_o", hsync, 16'h0);
        expect_equal("vsync_o", vsync, 16'h0);
        expect_equal("de_o", de, 16'h0);
        expect_equal("{red_o, green_o, blue_o}", 16'({red, green, blue}), 16'h0);
        expect_equal("bus_data_o", bus_data_out, 16'h0);

        // register readback
        value = 16'($random(seed));
        write_word(REG_ADDR, value);
        check_word(REG_ADDR, value);
        write_word(REG_PAL_ADDR, 16'h000b);
        check_word(REG_PAL_ADDR, 16'h000b);

        // fill the displayed words
        write_word(REG_ADDR, 16'h0000);
        for (int i = 0; i < NUM_WORDS; i++) begin
            vram_model[i] = 16'($random(seed));
            write_word(REG_DATA, vram_model[i]);
        end

        // each data write moves the address and prefetches the next word
        write_word(REG_ADDR, 16'd5);
        for (int a = 5; a < 8; a++) begin
            check_word(REG_DATA, vram_model[a]);
            check_word(REG_ADDR, 16'(a));
            if (a < 7) begin
                vram_model[a] = 16'($random(seed));
                write_word(REG_DATA, vram_model[a]);
            end
        end

        write_word(REG_PAL_ADDR, 16'h0000);
        for (int i = 0; i < 16; i++) begin
            value        = 16'($random(seed));
            pal_model[i] = value[11:0];         // top nibble ignored
            write_word(REG_PAL_DATA, value);
        end
        check_word(REG_PAL_ADDR, 16'h0000);     // index wrapped
        write_word(REG_CTRL, 16'h0001);
        check_word(REG_CTRL, 16'h0001);

        wait_frame_start();
        check_frame_pixels();

        // video off, sync keeps running
        write_word(REG_CTRL, 16'h0000);
        wait_frame_start();
        check_blank_frame();

        if (dut_i.props_i.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("bound assertions reported %0d failures", dut_i.props_i.fail_count);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- video_core.f
design/video_pkg.sv
design/vram_port_if.sv
design/bus_regs.sv
design/vram_arbiter.sv
design/video_scan.sv
design/palette_out.sv
design/video_core.sv
tb/video_core_properties.sv
tb/video_core_tb.sv
